// File: hw/rvga_consts.svh
`ifndef RVGA_CONSTS_SVH
`define RVGA_CONSTS_SVH

// ==================================================
// front end sizing
// ==================================================

// decode lanes, also words per fetch group
// must stay a power of two
`define RVGA_LANES 2

`define RVGA_XLEN 32 // word width

// bytes covered by one fetch group
`define RVGA_GRP_BYTES (4 * `RVGA_LANES)

// first fetch address out of reset
`define RVGA_RESET_PC 32'h0000_0000

// ==================================================
// wishbone
// ==================================================

`define RVGA_WB_AW 32 // byte address width

`endif

// File: hw/rvga_pkg.sv
package rvga_pkg;

`include "rvga_consts.svh"

  typedef logic [`RVGA_XLEN-1:0] rvga_word;
  typedef logic [4:0] rvga_reg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    e_rvga_opcode_lui   = 7'b0110111,
    e_rvga_opcode_auipc = 7'b0010111,
    e_rvga_opcode_jal   = 7'b1101111,
    e_rvga_opcode_jalr  = 7'b1100111,
    e_rvga_opcode_br    = 7'b1100011,
    e_rvga_opcode_ld    = 7'b0000011,
    e_rvga_opcode_st    = 7'b0100011,
    e_rvga_opcode_imm   = 7'b0010011,
    e_rvga_opcode_reg   = 7'b0110011
  } rvga_opcode_e;

  typedef enum logic [2:0] {
    e_rvga_inst_type_r,
    e_rvga_inst_type_i,
    e_rvga_inst_type_s,
    e_rvga_inst_type_b,
    e_rvga_inst_type_u,
    e_rvga_inst_type_j,
    e_rvga_inst_type_e  // unknown format
  } rvga_inst_type_e;

  // funct3 of the alu ops
  typedef enum logic [2:0] {
    e_rvga_artop_addsub = 3'b000,
    e_rvga_artop_sll    = 3'b001,
    e_rvga_artop_slt    = 3'b010,
    e_rvga_artop_sltu   = 3'b011,
    e_rvga_artop_xor    = 3'b100,
    e_rvga_artop_srx    = 3'b101,
    e_rvga_artop_or     = 3'b110,
    e_rvga_artop_and    = 3'b111
  } rvga_artop_e;

  // control word, 12 bits
  typedef struct packed {
    logic       rd_w_v;
    logic       dcache_w_v;
    logic       dcache_r_v;
    logic       imm_v;
    logic       imm_passthrough_v;
    logic       rs1_pc_sel;
    logic       alt_art;
    logic       jump_v;
    logic       illegal;
    logic [2:0] funct3;
  } rvga_cword_s;

endpackage : rvga_pkg

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`include "rvga_consts.svh"

module fetch_unit (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  rvga_pkg::rvga_word                  wb_dat_i,
  input  logic                                wb_ack_i,
  input  logic                                coll_free_i,
  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic [`RVGA_WB_AW-1:0]              wb_adr_o,
  output logic                                wb_we_o,
  output logic                                grp_valid_o,
  output rvga_pkg::rvga_word                  grp_pc_o,
  output rvga_pkg::rvga_word [`RVGA_LANES-1:0] grp_inst_o
);

  localparam int CNT_W = (`RVGA_LANES > 1) ? $clog2(`RVGA_LANES) : 1;
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`RVGA_LANES - 1);

  // gap keeps cyc low for a cycle between reads
  typedef enum logic [1:0] {
    S_GAP,
    S_REQ,
    S_HOLD
  } state_e;

  state_e                               state_q;
  logic [CNT_W-1:0]                     word_cnt_q;
  rvga_pkg::rvga_word                   fetch_pc_q;
  rvga_pkg::rvga_word [`RVGA_LANES-1:0] grp_buf_q;
  rvga_pkg::rvga_word                   word_adr;

  assign word_adr = fetch_pc_q + (rvga_pkg::rvga_word'(word_cnt_q) << 2);

  // ==================================================
  // wishbone master
  // ==================================================

  assign wb_cyc_o = (state_q == S_REQ);
  assign wb_stb_o = (state_q == S_REQ);
  assign wb_adr_o = `RVGA_WB_AW'(word_adr);
  assign wb_we_o  = 1'b0; // reads only

  assign grp_valid_o = (state_q == S_HOLD) && coll_free_i;
  assign grp_pc_o    = fetch_pc_q;
  assign grp_inst_o  = grp_buf_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= S_GAP;
      word_cnt_q <= '0;
      fetch_pc_q <= `RVGA_RESET_PC;
    end else begin
      case (state_q)
        S_GAP: state_q <= S_REQ;
        S_REQ: begin
          if (wb_ack_i) begin
            if (word_cnt_q == LAST_WORD) begin
              word_cnt_q <= '0;
              state_q    <= S_HOLD; // group full
            end else begin
              word_cnt_q <= word_cnt_q + 1'b1;
              state_q    <= S_GAP;
            end
          end
        end
        S_HOLD: begin
          // issue, then move on to the next group
          if (coll_free_i) begin
            fetch_pc_q <= fetch_pc_q + `RVGA_GRP_BYTES;
            state_q    <= S_GAP;
          end
        end
        default: state_q <= S_GAP;
      endcase
    end
  end

  // group buffer
  always_ff @(posedge clk_i) begin
    if (wb_stb_o && wb_ack_i) begin
      grp_buf_q[word_cnt_q] <= wb_dat_i;
    end
  end

  // ==================================================
  // bus checks
  // ==================================================

  // a stalled strobe keeps its address until ack
  a_adr_hold: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o))
  );

endmodule : fetch_unit

// File: hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  rvga_pkg::rvga_word    pc_i,
  input  rvga_pkg::rvga_word    inst_i,
  output logic                  valid_o,
  output rvga_pkg::rvga_word    pc_o,
  output rvga_pkg::rvga_reg     rs1_o,
  output rvga_pkg::rvga_reg     rs2_o,
  output rvga_pkg::rvga_reg     rd_o,
  output rvga_pkg::rvga_word    imm_o,
  output rvga_pkg::rvga_cword_s cword_o
);

  rvga_pkg::rvga_opcode_e    opcode;
  rvga_pkg::rvga_inst_type_e inst_type;
  rvga_pkg::rvga_artop_e     artop;
  rvga_pkg::rvga_cword_s     cword_d;
  rvga_pkg::rvga_word        imm;
  logic                      is_shift;

  assign opcode = rvga_pkg::rvga_opcode_e'(inst_i[6:0]);
  assign artop  = rvga_pkg::rvga_artop_e'(inst_i[14:12]);

  // ==================================================
  // opcode decode
  // ==================================================

  always_comb begin
    cword_d        = '0;
    cword_d.funct3 = inst_i[14:12];
    inst_type      = rvga_pkg::e_rvga_inst_type_e;

    case (opcode)
      rvga_pkg::e_rvga_opcode_br: begin
        inst_type = rvga_pkg::e_rvga_inst_type_b;
      end
      rvga_pkg::e_rvga_opcode_lui: begin
        inst_type                 = rvga_pkg::e_rvga_inst_type_u;
        cword_d.imm_v             = 1'b1;
        cword_d.rd_w_v            = 1'b1;
        cword_d.imm_passthrough_v = 1'b1;
      end
      rvga_pkg::e_rvga_opcode_auipc: begin
        inst_type          = rvga_pkg::e_rvga_inst_type_u;
        cword_d.imm_v      = 1'b1;
        cword_d.rd_w_v     = 1'b1;
        cword_d.rs1_pc_sel = 1'b1; // pc + imm
      end
      rvga_pkg::e_rvga_opcode_reg: begin
        inst_type      = rvga_pkg::e_rvga_inst_type_r;
        cword_d.rd_w_v = 1'b1;
        if ((artop == rvga_pkg::e_rvga_artop_addsub) ||
            (artop == rvga_pkg::e_rvga_artop_srx)) begin
          cword_d.alt_art = inst_i[30]; // sub / sra
        end
      end
      rvga_pkg::e_rvga_opcode_imm: begin
        inst_type      = rvga_pkg::e_rvga_inst_type_i;
        cword_d.imm_v  = 1'b1;
        cword_d.rd_w_v = 1'b1;
        if (artop == rvga_pkg::e_rvga_artop_srx) begin
          cword_d.alt_art = inst_i[30]; // srai
        end
      end
      rvga_pkg::e_rvga_opcode_ld: begin
        inst_type          = rvga_pkg::e_rvga_inst_type_i;
        cword_d.imm_v      = 1'b1;
        cword_d.dcache_r_v = 1'b1;
        cword_d.rd_w_v     = 1'b1;
      end
      rvga_pkg::e_rvga_opcode_st: begin
        inst_type          = rvga_pkg::e_rvga_inst_type_s;
        cword_d.imm_v      = 1'b1;
        cword_d.dcache_w_v = 1'b1;
      end
      rvga_pkg::e_rvga_opcode_jal: begin
        inst_type          = rvga_pkg::e_rvga_inst_type_j;
        cword_d.rd_w_v     = 1'b1;
        cword_d.jump_v     = 1'b1;
        cword_d.rs1_pc_sel = 1'b1;
      end
      rvga_pkg::e_rvga_opcode_jalr: begin
        inst_type      = rvga_pkg::e_rvga_inst_type_i;
        cword_d.rd_w_v = 1'b1;
        cword_d.jump_v = 1'b1;
        cword_d.imm_v  = 1'b1;
      end
      default: begin
        cword_d.funct3  = '0;
        cword_d.illegal = 1'b1;
      end
    endcase
  end

  // ==================================================
  // immediate
  // ==================================================

  // only alu shifts carry a shamt
  assign is_shift = (opcode == rvga_pkg::e_rvga_opcode_imm) &&
                    ((artop == rvga_pkg::e_rvga_artop_sll) ||
                     (artop == rvga_pkg::e_rvga_artop_srx));

  always_comb begin
    case (inst_type)
      rvga_pkg::e_rvga_inst_type_i: begin
        if (is_shift) begin
          imm = {27'b0, inst_i[24:20]};
        end else begin
          imm = {{20{inst_i[31]}}, inst_i[31:20]};
        end
      end
      rvga_pkg::e_rvga_inst_type_s:
        imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
      rvga_pkg::e_rvga_inst_type_b:
        imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      rvga_pkg::e_rvga_inst_type_u:
        imm = {inst_i[31:12], 12'b0};
      rvga_pkg::e_rvga_inst_type_j:
        imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      default: imm = '0; // r and unknown
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
      pc_o    <= '0;
      rs1_o   <= '0;
      rs2_o   <= '0;
      rd_o    <= '0;
      imm_o   <= '0;
      cword_o <= '0;
    end else begin
      valid_o <= valid_i;
      pc_o    <= pc_i;
      rs1_o   <= inst_i[19:15];
      rs2_o   <= inst_i[24:20];
      rd_o    <= inst_i[11:7];
      imm_o   <= imm;
      cword_o <= cword_d;
    end
  end

  a_mem_dir: assert property (
    @(posedge clk_i) disable iff (rst_i)
    valid_o |-> !(cword_o.dcache_r_v && cword_o.dcache_w_v)
  );

endmodule : decode_stage

// File: hw/decode_collector.sv
`timescale 1ns/1ns
`include "rvga_consts.svh"

module decode_collector (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic [`RVGA_LANES-1:0]                 lane_valid_i,
  input  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    lane_pc_i,
  input  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    lane_imm_i,
  input  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rs1_i,
  input  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rs2_i,
  input  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rd_i,
  input  rvga_pkg::rvga_cword_s [`RVGA_LANES-1:0] lane_cword_i,
  input  logic                                   dec_ready_i,
  output logic                                   coll_free_o,
  output logic                                   dec_valid_o,
  output rvga_pkg::rvga_word                     dec_pc_o,
  output rvga_pkg::rvga_word                     dec_imm_o,
  output rvga_pkg::rvga_reg                      dec_rs1_o,
  output rvga_pkg::rvga_reg                      dec_rs2_o,
  output rvga_pkg::rvga_reg                      dec_rd_o,
  output rvga_pkg::rvga_cword_s                  dec_cword_o
);

  localparam int IDX_W = (`RVGA_LANES > 1) ? $clog2(`RVGA_LANES) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`RVGA_LANES - 1);

  logic             full_q;
  logic [IDX_W-1:0] idx_q; // drain position
  logic             capture;
  logic             xfer;

  // result bank
  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    pc_q;
  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    imm_q;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     rs1_q;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     rs2_q;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     rd_q;
  rvga_pkg::rvga_cword_s [`RVGA_LANES-1:0] cword_q;

  assign capture = &lane_valid_i; // lanes fire together
  assign xfer    = full_q && dec_ready_i;

  assign coll_free_o = !full_q;
  assign dec_valid_o = full_q;
  assign dec_pc_o    = pc_q[idx_q];
  assign dec_imm_o   = imm_q[idx_q];
  assign dec_rs1_o   = rs1_q[idx_q];
  assign dec_rs2_o   = rs2_q[idx_q];
  assign dec_rd_o    = rd_q[idx_q];
  assign dec_cword_o = cword_q[idx_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (capture) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (xfer) begin
      if (idx_q == LAST_IDX) begin
        full_q <= 1'b0; // free again next cycle
        idx_q  <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      pc_q    <= lane_pc_i;
      imm_q   <= lane_imm_i;
      rs1_q   <= lane_rs1_i;
      rs2_q   <= lane_rs2_i;
      rd_q    <= lane_rd_i;
      cword_q <= lane_cword_i;
    end
  end

  // ==================================================
  // stream checks
  // ==================================================

  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (dec_valid_o && !dec_ready_i) |=>
      (dec_valid_o && $stable(dec_pc_o) && $stable(dec_imm_o) &&
       $stable(dec_rs1_o) && $stable(dec_rs2_o) && $stable(dec_rd_o) &&
       $stable(dec_cword_o))
  );

  // fetch must wait for coll_free before issuing
  a_capture_free: assert property (
    @(posedge clk_i) disable iff (rst_i)
    capture |-> coll_free_o
  );

endmodule : decode_collector

// File: hw/rvga_frontend.sv
`timescale 1ns/1ns
`include "rvga_consts.svh"

module rvga_frontend (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  rvga_pkg::rvga_word     wb_dat_i,
  input  logic                   wb_ack_i,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic [`RVGA_WB_AW-1:0] wb_adr_o,
  input  logic                   dec_ready_i,
  output logic                   dec_valid_o,
  output rvga_pkg::rvga_word     dec_pc_o,
  output rvga_pkg::rvga_word     dec_imm_o,
  output rvga_pkg::rvga_reg      dec_rs1_o,
  output rvga_pkg::rvga_reg      dec_rs2_o,
  output rvga_pkg::rvga_reg      dec_rd_o,
  output rvga_pkg::rvga_cword_s  dec_cword_o
);

  logic                                 coll_free;
  logic                                 grp_valid;
  rvga_pkg::rvga_word                   grp_pc;
  rvga_pkg::rvga_word [`RVGA_LANES-1:0] grp_inst;

  // lane results
  logic [`RVGA_LANES-1:0]                 lane_valid;
  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    lane_pc;
  rvga_pkg::rvga_word [`RVGA_LANES-1:0]    lane_imm;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rs1;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rs2;
  rvga_pkg::rvga_reg [`RVGA_LANES-1:0]     lane_rd;
  rvga_pkg::rvga_cword_s [`RVGA_LANES-1:0] lane_cword;

  fetch_unit fetch_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .coll_free_i (coll_free),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_adr_o    (wb_adr_o),
    .wb_we_o     (),            // always read
    .grp_valid_o (grp_valid),
    .grp_pc_o    (grp_pc),
    .grp_inst_o  (grp_inst)
  );

  for (genvar k = 0; k < `RVGA_LANES; k++) begin : lane_g
    decode_stage dec_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (grp_valid),
      .pc_i    (grp_pc + rvga_pkg::rvga_word'(4 * k)), // word k of the group
      .inst_i  (grp_inst[k]),
      .valid_o (lane_valid[k]),
      .pc_o    (lane_pc[k]),
      .rs1_o   (lane_rs1[k]),
      .rs2_o   (lane_rs2[k]),
      .rd_o    (lane_rd[k]),
      .imm_o   (lane_imm[k]),
      .cword_o (lane_cword[k])
    );
  end

  decode_collector coll_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_valid_i (lane_valid),
    .lane_pc_i    (lane_pc),
    .lane_imm_i   (lane_imm),
    .lane_rs1_i   (lane_rs1),
    .lane_rs2_i   (lane_rs2),
    .lane_rd_i    (lane_rd),
    .lane_cword_i (lane_cword),
    .dec_ready_i  (dec_ready_i),
    .coll_free_o  (coll_free),
    .dec_valid_o  (dec_valid_o),
    .dec_pc_o     (dec_pc_o),
    .dec_imm_o    (dec_imm_o),
    .dec_rs1_o    (dec_rs1_o),
    .dec_rs2_o    (dec_rs2_o),
    .dec_rd_o     (dec_rd_o),
    .dec_cword_o  (dec_cword_o)
  );

endmodule : rvga_frontend

// File: test/tb_rvga_vectors.svh
`ifndef TB_RVGA_VECTORS_SVH
`define TB_RVGA_VECTORS_SVH

// columns: row, name, inst, rs1, rs2, rd, imm, flags, funct3
// flags msb first: rd_w_v dcache_w_v dcache_r_v imm_v imm_passthrough_v
//                  rs1_pc_sel alt_art jump_v illegal

localparam int NUM_ROWS = 16;

string       row_name  [NUM_ROWS];
logic [31:0] row_inst  [NUM_ROWS];
logic [4:0]  row_rs1   [NUM_ROWS];
logic [4:0]  row_rs2   [NUM_ROWS];
logic [4:0]  row_rd    [NUM_ROWS];
logic [31:0] row_imm   [NUM_ROWS];
logic [8:0]  row_flags [NUM_ROWS];
logic [2:0]  row_f3    [NUM_ROWS];

task automatic put_row(input int idx, input string name, input logic [31:0] inst,
                       input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                       input logic [31:0] imm, input logic [8:0] flags,
                       input logic [2:0] f3);
  row_name[idx]  = name;
  row_inst[idx]  = inst;
  row_rs1[idx]   = rs1;
  row_rs2[idx]   = rs2;
  row_rd[idx]    = rd;
  row_imm[idx]   = imm;
  row_flags[idx] = flags;
  row_f3[idx]    = f3;
endtask

task automatic load_table();
  put_row(0,  "addi",    32'h00500093, 0,  5,  1,  32'h00000005, 9'b100100000, 3'b000);
  put_row(1,  "addi_n",  32'hff808113, 1,  24, 2,  32'hfffffff8, 9'b100100000, 3'b000);
  put_row(2,  "slli",    32'h00711193, 2,  7,  3,  32'h00000007, 9'b100100000, 3'b001);
  put_row(3,  "srai",    32'h41f1d213, 3,  31, 4,  32'h0000001f, 9'b100100100, 3'b101);
  put_row(4,  "sub",     32'h403202b3, 4,  3,  5,  32'h00000000, 9'b100000100, 3'b000);
  put_row(5,  "xor_b30", 32'h4042c333, 5,  4,  6,  32'h00000000, 9'b100000000, 3'b100);
  put_row(6,  "lw",      32'h00c32383, 6,  12, 7,  32'h0000000c, 9'b101100000, 3'b010);
  put_row(7,  "sw",      32'hfe712e23, 2,  7,  28, 32'hfffffffc, 9'b010100000, 3'b010);
  put_row(8,  "beq",     32'h00208863, 1,  2,  16, 32'h00000010, 9'b000000000, 3'b000);
  put_row(9,  "bne_n",   32'hfe419ce3, 3,  4,  25, 32'hfffffff8, 9'b000000000, 3'b001);
  put_row(10, "lui",     32'h12345537, 8,  3,  10, 32'h12345000, 9'b100110000, 3'b101);
  put_row(11, "auipc",   32'hfffff597, 31, 31, 11, 32'hfffff000, 9'b100101000, 3'b111);
  put_row(12, "jal",     32'h001000ef, 0,  1,  1,  32'h00000800, 9'b100001010, 3'b000);
  put_row(13, "jalr",    32'h064280e7, 5,  4,  1,  32'h00000064, 9'b100100010, 3'b000);
  put_row(14, "illegal", 32'hffffffff, 31, 31, 31, 32'h00000000, 9'b000000001, 3'b000);
  put_row(15, "jal_n",   32'hffdff06f, 31, 29, 0,  32'hfffffffc, 9'b100001010, 3'b111);
endtask

`endif

// File: test/tb_rvga_frontend.sv
`timescale 1ns/1ns
`include "rvga_consts.svh"

module tb_rvga_frontend;

  `include "tb_rvga_vectors.svh"

  localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 50;

  logic                   clk_i;
  logic                   rst_i;
  rvga_pkg::rvga_word     wb_dat_i;
  logic                   wb_ack_i;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic [`RVGA_WB_AW-1:0] wb_adr_o;
  logic                   dec_ready_i;
  logic                   dec_valid_o;
  rvga_pkg::rvga_word     dec_pc_o;
  rvga_pkg::rvga_word     dec_imm_o;
  rvga_pkg::rvga_reg      dec_rs1_o;
  rvga_pkg::rvga_reg      dec_rs2_o;
  rvga_pkg::rvga_reg      dec_rd_o;
  rvga_pkg::rvga_cword_s  dec_cword_o;

  logic        bus_busy; // memory model mid-access
  int          wait_left;
  int          stretch_left;
  logic        ready_level;

  int          err_cnt;
  int          test_cnt;
  int          test_fail;
  int          pc_err;
  int          hold_cnt;
  int          hold_err;
  int          cycle_cnt;
  logic        held;
  logic [90:0] held_bits;

  rvga_frontend dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_adr_o    (wb_adr_o),
    .dec_ready_i (dec_ready_i),
    .dec_valid_o (dec_valid_o),
    .dec_pc_o    (dec_pc_o),
    .dec_imm_o   (dec_imm_o),
    .dec_rs1_o   (dec_rs1_o),
    .dec_rs2_o   (dec_rs2_o),
    .dec_rd_o    (dec_rd_o),
    .dec_cword_o (dec_cword_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ==================================================
  // memory model and consumer
  // ==================================================

  // table word, past the table an address-derived fill
  function automatic rvga_pkg::rvga_word mem_word(input logic [`RVGA_WB_AW-1:0] adr);
    if ((adr >> 2) < NUM_ROWS) begin
      return row_inst[adr >> 2];
    end
    return adr ^ 32'h9e37_79b9;
  endfunction

  function automatic logic [90:0] out_bits();
    return {dec_pc_o, dec_imm_o, dec_rs1_o, dec_rs2_o, dec_rd_o, dec_cword_o};
  endfunction

  task automatic serve_bus();
    if (wb_ack_i) begin
      wb_ack_i <= 1'b0; // single-cycle ack
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        wait_left = $urandom_range(2, 0);
      end
      if (wait_left == 0) begin
        wb_ack_i <= 1'b1;
        wb_dat_i <= mem_word(wb_adr_o);
        bus_busy  = 1'b0;
      end else begin
        wait_left--;
      end
    end
  endtask

  // ready comes in stretches of 1 to 6 cycles
  task automatic drive_ready();
    if (stretch_left == 0) begin
      ready_level  = ($urandom_range(99, 0) < 65);
      stretch_left = $urandom_range(6, 1);
    end
    stretch_left--;
    dec_ready_i <= ready_level;
  endtask

  initial begin
    rst_i        = 1'b1;
    wb_ack_i     = 1'b0;
    wb_dat_i     = '0;
    dec_ready_i  = 1'b0;
    bus_busy     = 1'b0;
    wait_left    = 0;
    ready_level  = 1'b0;
    stretch_left = $urandom(17723) % 4; // seeds the run
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    forever begin
      @(posedge clk_i);
      serve_bus();
      drive_ready();
    end
  end

  // ==================================================
  // checks
  // ==================================================

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      test_fail++;
      $display("test %s: %0d mismatches", name, err_cnt - errs_before);
    end
  endtask

  task automatic check_reset();
    int errs_before;
    errs_before = err_cnt;
    @(posedge clk_i);
    assert (!wb_cyc_o && !wb_stb_o && !dec_valid_o) else begin
      $display("FAILED t=%0t: bus or output active after reset", $time);
      err_cnt++;
    end
    @(posedge clk_i); // first fetch should be up now
    assert (wb_cyc_o && wb_stb_o && wb_adr_o == `RVGA_RESET_PC) else begin
      $display("FAILED t=%0t: first fetch cyc %b stb %b adr %h", $time,
               wb_cyc_o, wb_stb_o, wb_adr_o);
      err_cnt++;
    end
    finish_test("reset", errs_before);
  endtask

  task automatic check_hold();
    if (held) begin
      hold_cnt++;
      assert (dec_valid_o && out_bits() == held_bits) else begin
        $display("FAILED t=%0t: held output changed, valid %b pc %h was %h", $time,
                 dec_valid_o, dec_pc_o, held_bits[90:59]);
        err_cnt++;
        hold_err++;
      end
    end
    held      = dec_valid_o && !dec_ready_i;
    held_bits = out_bits();
  endtask

  task automatic wait_transfer();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(posedge clk_i);
      check_hold();
      seen = dec_valid_o && dec_ready_i;
    end
  endtask

  task automatic check_row(input int r);
    int                    errs_before;
    rvga_pkg::rvga_cword_s exp_cword;
    errs_before = err_cnt;
    exp_cword   = {row_flags[r], row_f3[r]};
    assert (dec_pc_o == 32'(4 * r)) else begin
      $display("FAILED t=%0t: row %0d pc %h, expected %h", $time, r, dec_pc_o, 4 * r);
      err_cnt++;
      pc_err++;
    end
    assert (dec_rs1_o == row_rs1[r] && dec_rs2_o == row_rs2[r] && dec_rd_o == row_rd[r])
    else begin
      $display("FAILED t=%0t: row %0d regs %0d %0d %0d, expected %0d %0d %0d", $time, r,
               dec_rs1_o, dec_rs2_o, dec_rd_o, row_rs1[r], row_rs2[r], row_rd[r]);
      err_cnt++;
    end
    assert (dec_imm_o == row_imm[r]) else begin
      $display("FAILED t=%0t: row %0d imm %h, expected %h", $time, r, dec_imm_o, row_imm[r]);
      err_cnt++;
    end
    assert (dec_cword_o == exp_cword) else begin
      $display("FAILED t=%0t: row %0d cword %b, expected %b", $time, r, dec_cword_o,
               exp_cword);
      err_cnt++;
    end
    finish_test($sformatf("row %0d %s", r, row_name[r]), errs_before);
  endtask

  task automatic report_stream();
    test_cnt++;
    if (pc_err == 0) begin
      $display("test ordering: %0d entries in table order", NUM_ROWS);
    end else begin
      test_fail++;
      $display("test ordering: %0d entries out of place", pc_err);
    end
    assert (hold_cnt > 0) else begin
      $display("back-pressure never held an output, stall path not exercised");
      err_cnt++;
      hold_err++;
    end
    test_cnt++;
    if (hold_err == 0) begin
      $display("test back-pressure: %0d held cycles stable", hold_cnt);
    end else begin
      test_fail++;
      $display("test back-pressure: %0d errors over %0d held cycles", hold_err, hold_cnt);
    end
  endtask

  initial begin
    err_cnt   = 0;
    test_cnt  = 0;
    test_fail = 0;
    pc_err    = 0;
    hold_cnt  = 0;
    hold_err  = 0;
    held      = 1'b0;
    held_bits = '0;
    load_table();
    wait (rst_i === 1'b0);
    check_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      wait_transfer();
      check_row(r);
    end
    report_stream();
    $display("tests run %0d, failed %0d, mismatches %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0 && test_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_rvga_frontend

// File: src.f
+incdir+hw
+incdir+test
hw/rvga_pkg.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/decode_collector.sv
hw/rvga_frontend.sv
test/tb_rvga_frontend.sv
